//--- project.f
rtl/cache_pkg.sv
rtl/cache_way.sv
rtl/lru_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
testbench/tb_clock.sv
testbench/mem_model.sv
testbench/tb_cache.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator; exit status follows the result
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_cache -f project.f -o sim_cache \
    && ./obj_dir/sim_cache > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "^TEST OK$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

//--- testbench/tb_cache.sv
`timescale 1ns/100ps
// directed table test of the cache against a shadow word memory
// table addresses stay below line 256, so the memory model never aliases
module tb_cache;
    import cache_pkg::*;

    localparam int          INDEX_W      = INDEX_W_DEFAULT;
    localparam logic [31:0] SEED         = 32'hfefc_c5fc;
    localparam logic [31:0] TAPS         = 32'h8020_0003;
    localparam logic [31:0] RULE_KEY     = 32'hA5A5_0000;
    localparam int          SHADOW_WORDS = 1024;
    localparam int          TIMEOUT      = 200;
    localparam int          STIM_DELAY   = 2;
    localparam int          NUM_ROWS     = 21;

    localparam logic OP_RD = 1'b0;
    localparam logic OP_WR = 1'b1;

    typedef struct packed {
        logic       op;
        logic [9:0] addr;      // word address
        logic [3:0] be;
        word_t      data;
        logic       rnd;       // data comes from the LFSR
        logic       hit;       // expect a hit: fixed timing, no memory read
        logic       wb;        // expect one write-back
        logic [7:0] wb_line;
    } row_t;

    // set 5 holds lines 05 15 25 35 45 55; write-backs follow the touch order
    row_t rows [NUM_ROWS] = '{
        '{OP_RD, 10'h010, 4'hf, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 8'h00},
        '{OP_RD, 10'h010, 4'hf, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 8'h00},
        '{OP_RD, 10'h013, 4'hf, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 8'h00},
        '{OP_WR, 10'h011, 4'h5, 32'h1122_3344, 1'b0, 1'b1, 1'b0, 8'h00},
        '{OP_RD, 10'h011, 4'hf, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 8'h00},
        '{OP_WR, 10'h022, 4'hf, 32'h0000_0000, 1'b1, 1'b0, 1'b0, 8'h00},
        '{OP_RD, 10'h022, 4'hf, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 8'h00},
        '{OP_RD, 10'h020, 4'hf, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 8'h00},
        '{OP_RD, 10'h023, 4'hf, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 8'h00},
        '{OP_WR, 10'h014, 4'hf, 32'h0000_0000, 1'b1, 1'b0, 1'b0, 8'h00},
        '{OP_WR, 10'h055, 4'h3, 32'h0000_0000, 1'b1, 1'b0, 1'b0, 8'h00},
        '{OP_WR, 10'h096, 4'hc, 32'h0000_0000, 1'b1, 1'b0, 1'b0, 8'h00},
        '{OP_WR, 10'h0d7, 4'hf, 32'h0000_0000, 1'b1, 1'b0, 1'b0, 8'h00},
        '{OP_RD, 10'h014, 4'hf, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 8'h00},
        '{OP_WR, 10'h115, 4'hf, 32'h0000_0000, 1'b1, 1'b0, 1'b1, 8'h15},
        '{OP_RD, 10'h154, 4'hf, 32'h0000_0000, 1'b0, 1'b0, 1'b1, 8'h25},
        '{OP_RD, 10'h055, 4'hf, 32'h0000_0000, 1'b0, 1'b0, 1'b1, 8'h35},
        '{OP_RD, 10'h096, 4'hf, 32'h0000_0000, 1'b0, 1'b0, 1'b1, 8'h05},
        '{OP_RD, 10'h0d7, 4'hf, 32'h0000_0000, 1'b0, 1'b0, 1'b1, 8'h45},
        '{OP_WR, 10'h0d7, 4'h8, 32'h5a00_0000, 1'b0, 1'b1, 1'b0, 8'h00},
        '{OP_RD, 10'h0d7, 4'hf, 32'h0000_0000, 1'b0, 1'b1, 1'b0, 8'h00}
    };

    logic       clk;
    logic       rst;
    p_req_t     p_req;
    word_t      p_readdata;
    logic       p_readdata_valid;
    logic       p_waitrequest;
    line_addr_t m_addr;
    line_u      m_writedata;
    line_u      m_readdata;
    logic       m_read;
    logic       m_write;
    logic       m_readdata_valid;
    logic       m_waitrequest;
    int         m_read_count;
    int         m_write_count;

    word_t       shadow [SHADOW_WORDS];
    logic [31:0] lfsr = SEED;
    int          errors;
    int          checks;
    logic        timed_out;

    tb_clock u_clk (
        .o_clk (clk),
        .o_rst (rst)
    );

    cache_top #(.INDEX_W(INDEX_W)) dut (
        .clk                (clk),
        .rst                (rst),
        .i_p_req            (p_req),
        .o_p_readdata       (p_readdata),
        .o_p_readdata_valid (p_readdata_valid),
        .o_p_waitrequest    (p_waitrequest),
        .o_m_addr           (m_addr),
        .o_m_writedata      (m_writedata),
        .o_m_read           (m_read),
        .o_m_write          (m_write),
        .i_m_readdata       (m_readdata),
        .i_m_readdata_valid (m_readdata_valid),
        .i_m_waitrequest    (m_waitrequest)
    );

    mem_model u_mem (
        .clk              (clk),
        .rst              (rst),
        .i_addr           (m_addr),
        .i_writedata      (m_writedata),
        .i_read           (m_read),
        .i_write          (m_write),
        .o_readdata       (m_readdata),
        .o_readdata_valid (m_readdata_valid),
        .o_waitrequest    (m_waitrequest),
        .o_read_count     (m_read_count),
        .o_write_count    (m_write_count)
    );

    function automatic word_t rule_word(int addr);
        return word_t'(addr) ^ RULE_KEY;
    endfunction

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
    endfunction

    task automatic random_word(output word_t w);
        for (int i = 0; i < 32; i++) begin
            w[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #STIM_DELAY;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0d ns: %s", $time, what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (p_waitrequest && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (p_waitrequest) begin
            report_timeout("the cache stayed busy before a new request");
        end
    endtask

    // called one cycle after the request, so a hit shows up at count 2
    task automatic wait_read(output int cycles, output word_t data);
        cycles = 1;
        while (!p_readdata_valid && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        data = p_readdata;
        if (!p_readdata_valid) begin
            report_timeout("no read data came back");
        end
    endtask

    task automatic wait_write(output int cycles);
        cycles = 0;
        while (p_waitrequest && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (p_waitrequest) begin
            report_timeout("a write never completed");
        end
    endtask

    task automatic run_row(input row_t r);
        p_req_t req;
        word_t  data;
        word_t  got;
        line_u  wb_exp;
        int     word_idx;
        int     rd_before;
        int     wr_before;
        int     cycles;
        data     = r.data;
        word_idx = int'(r.addr);
        if (r.rnd) begin
            random_word(data);
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            wb_exp.words[w] = shadow[int'(r.wb_line) * WORDS_PER_LINE + w];
        end
        req      = '0;
        req.rd   = (r.op == OP_RD);
        req.wr   = (r.op == OP_WR);
        req.addr = P_ADDR_W'(r.addr);
        req.be   = r.be;
        req.data = data;
        wait_idle();
        if (timed_out) begin
            return;
        end
        rd_before = m_read_count;
        wr_before = m_write_count;
        p_req = req;        // one-cycle strobe
        next_cycle();
        p_req = '0;
        if (r.op == OP_RD) begin
            wait_read(cycles, got);
            if (timed_out) begin
                return;
            end
            check("o_p_readdata", 128'(got), 128'(shadow[word_idx]));
            if (r.hit) begin
                check("o_p_readdata_valid delay", 128'(cycles), 128'(2));
            end
        end else begin
            wait_write(cycles);
            if (timed_out) begin
                return;
            end
            if (r.hit) begin
                check("o_p_waitrequest high cycles", 128'(cycles), 128'(2));
            end
            for (int b = 0; b < 4; b++) begin
                if (r.be[b]) begin
                    shadow[word_idx][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        check("o_m_read count", 128'(m_read_count - rd_before), 128'(r.hit ? 0 : 1));
        check("o_m_write count", 128'(m_write_count - wr_before), 128'(r.wb ? 1 : 0));
        if (r.wb && m_write_count > wr_before) begin
            check("o_m_addr", 128'(u_mem.log_addr[wr_before]), 128'(r.wb_line));
            check("o_m_writedata", u_mem.log_data[wr_before], wb_exp);
        end
    endtask

    initial begin
        int n;
        p_req     = '0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        for (int a = 0; a < SHADOW_WORDS; a++) begin
            shadow[a] = rule_word(a);
        end

        // rst is looked at on the edge, away from where it changes
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (rst && n < TIMEOUT);
        #STIM_DELAY;
        if (rst) begin
            report_timeout("reset was never released");
        end

        if (!timed_out) begin
            check("o_p_waitrequest", 128'(p_waitrequest), 128'(0));
            check("o_p_readdata_valid", 128'(p_readdata_valid), 128'(0));
            check("o_m_read", 128'(m_read), 128'(0));
            check("o_m_write", 128'(m_write), 128'(0));
            for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
                run_row(rows[i]);
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/mem_model.sv
`timescale 1ns/100ps
// line-wide memory of 256 lines; only the low 8 line-address bits are decoded
// waitrequest and read latency are random 0 to 3 cycles, one read in flight at a time
module mem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::line_addr_t i_addr,
    input  cache_pkg::line_u      i_writedata,
    input  logic                  i_read,
    input  logic                  i_write,
    output cache_pkg::line_u      o_readdata,
    output logic                  o_readdata_valid,
    output logic                  o_waitrequest,
    output int                    o_read_count,
    output int                    o_write_count
);
    import cache_pkg::*;

    localparam int          LINES     = 256;
    localparam int          LOG_DEPTH = 64;
    localparam logic [31:0] SEED      = 32'hfefc_c5fc;
    localparam logic [31:0] TAPS      = 32'h8020_0003;
    localparam logic [31:0] RULE_KEY  = 32'hA5A5_0000;

    line_u      mem      [LINES];
    line_addr_t log_addr [LOG_DEPTH];   // every accepted write, oldest first
    line_u      log_data [LOG_DEPTH];

    logic [31:0] lfsr      = SEED;
    int          wait_left = 0;        // stall cycles left for the next command
    int          lat_left  = 0;
    logic        pending   = 1'b0;
    logic [7:0]  pend_line = '0;
    line_u       rdata_q   = '0;
    logic        rvalid_q  = 1'b0;
    int          rd_cnt    = 0;
    int          wr_cnt    = 0;

    assign o_readdata       = rdata_q;
    assign o_readdata_valid = rvalid_q;
    assign o_waitrequest    = (wait_left != 0);
    assign o_read_count     = rd_cnt;
    assign o_write_count    = wr_cnt;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
    endfunction

    // two bits, one step each
    task automatic draw_count(output int n);
        logic [1:0] v;
        for (int i = 0; i < 2; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
        n = int'(v);
    endtask

    initial begin
        for (int l = 0; l < LINES; l++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem[l].words[w] = 32'(l * WORDS_PER_LINE + w) ^ RULE_KEY;
            end
        end
    end

    always @(posedge clk) begin
        int n;
        rvalid_q <= 1'b0;
        if (rst) begin
            pending <= 1'b0;
            draw_count(n);
            wait_left <= n;
        end else begin
            if (pending) begin
                if (lat_left == 0) begin
                    rdata_q  <= mem[pend_line];
                    rvalid_q <= 1'b1;
                    pending  <= 1'b0;
                end else begin
                    lat_left <= lat_left - 1;
                end
            end
            if (i_read || i_write) begin
                if (wait_left != 0) begin
                    wait_left <= wait_left - 1;
                end else begin
                    draw_count(n);      // stall for whatever command comes next
                    wait_left <= n;
                    if (i_write) begin
                        mem[i_addr[7:0]] <= i_writedata;
                        if (wr_cnt < LOG_DEPTH) begin
                            log_addr[wr_cnt] <= i_addr;
                            log_data[wr_cnt] <= i_writedata;
                        end
                        wr_cnt <= wr_cnt + 1;
                    end else begin
                        draw_count(n);
                        lat_left  <= n;
                        pend_line <= i_addr[7:0];
                        pending   <= 1'b1;
                        rd_cnt    <= rd_cnt + 1;
                    end
                end
            end
        end
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/100ps
// 40 ns clock, reset high through the first 4 rising edges
// reset drops 2 ns after an edge, like the other stimulus
module tb_clock #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #2 o_rst = 1'b0;
    end

endmodule

//--- rtl/cache_top.sv
`timescale 1ns/100ps
// 4-way write-back data cache, 128-bit lines, 2**INDEX_W sets
// processor requests are single-cycle strobes taken only while o_p_waitrequest is low
module cache_top #(
    parameter int INDEX_W = cache_pkg::INDEX_W_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::p_req_t     i_p_req,
    output cache_pkg::word_t      o_p_readdata,
    output logic                  o_p_readdata_valid,
    output logic                  o_p_waitrequest,
    output cache_pkg::line_addr_t o_m_addr,
    output cache_pkg::line_u      o_m_writedata,
    output logic                  o_m_read,
    output logic                  o_m_write,
    input  cache_pkg::line_u      i_m_readdata,
    input  logic                  i_m_readdata_valid,
    input  logic                  i_m_waitrequest
);
    import cache_pkg::*;

    localparam int TAG_W = LINE_ADDR_W - INDEX_W;

    logic [INDEX_W-1:0]             index;
    logic [TAG_W-1:0]               tag;
    way_mask_t                      wr_mask;
    logic [LINE_BYTES-1:0]          lane_en;
    line_u                          wdata;
    logic                           wr_dirty;
    line_u [NUM_WAYS-1:0]           way_line;
    logic [NUM_WAYS-1:0][TAG_W-1:0] way_tag;
    logic [NUM_WAYS-1:0]            way_valid;
    logic [NUM_WAYS-1:0]            way_dirty;
    logic                           touch;
    way_idx_t                       touch_way;
    way_idx_t                       victim;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way #(.INDEX_W(INDEX_W)) u_way (
            .clk       (clk),
            .rst       (rst),
            .i_index   (index),
            .i_tag     (tag),
            .i_wr      (wr_mask[w]),
            .i_lane_en (lane_en),
            .i_wdata   (wdata),
            .i_dirty   (wr_dirty),
            .o_line    (way_line[w]),
            .o_tag     (way_tag[w]),
            .o_valid   (way_valid[w]),
            .o_dirty   (way_dirty[w])
        );
    end

    lru_store #(.INDEX_W(INDEX_W)) u_lru (
        .clk      (clk),
        .rst      (rst),
        .i_index  (index),
        .i_touch  (touch),
        .i_way    (touch_way),
        .o_victim (victim)
    );

    cache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .i_p_req            (i_p_req),
        .i_line             (way_line),
        .i_tag              (way_tag),
        .i_valid            (way_valid),
        .i_dirty            (way_dirty),
        .i_victim           (victim),
        .i_m_readdata       (i_m_readdata),
        .i_m_readdata_valid (i_m_readdata_valid),
        .i_m_waitrequest    (i_m_waitrequest),
        .o_p_readdata       (o_p_readdata),
        .o_p_readdata_valid (o_p_readdata_valid),
        .o_p_waitrequest    (o_p_waitrequest),
        .o_index            (index),
        .o_tag              (tag),
        .o_wr_mask          (wr_mask),
        .o_lane_en          (lane_en),
        .o_wdata            (wdata),
        .o_dirty            (wr_dirty),
        .o_touch            (touch),
        .o_touch_way        (touch_way),
        .o_m_addr           (o_m_addr),
        .o_m_writedata      (o_m_writedata),
        .o_m_read           (o_m_read),
        .o_m_write          (o_m_write)
    );

endmodule

//--- rtl/cache_ctrl.sv
`timescale 1ns/100ps
// write-back, write-allocate controller with one request in flight
// memory read and write commands stay up until i_m_waitrequest is sampled low
module cache_ctrl #(
    parameter int INDEX_W = cache_pkg::INDEX_W_DEFAULT,
    localparam int TAG_W = cache_pkg::LINE_ADDR_W - INDEX_W
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  cache_pkg::p_req_t                             i_p_req,
    input  cache_pkg::line_u [cache_pkg::NUM_WAYS-1:0]    i_line,
    input  logic [cache_pkg::NUM_WAYS-1:0][TAG_W-1:0]     i_tag,
    input  logic [cache_pkg::NUM_WAYS-1:0]                i_valid,
    input  logic [cache_pkg::NUM_WAYS-1:0]                i_dirty,
    input  cache_pkg::way_idx_t                           i_victim,
    input  cache_pkg::line_u                              i_m_readdata,
    input  logic                                          i_m_readdata_valid,
    input  logic                                          i_m_waitrequest,
    output cache_pkg::word_t                              o_p_readdata,
    output logic                                          o_p_readdata_valid,
    output logic                                          o_p_waitrequest,
    output logic [INDEX_W-1:0]                            o_index,
    output logic [TAG_W-1:0]                              o_tag,
    output cache_pkg::way_mask_t                          o_wr_mask,
    output logic [cache_pkg::LINE_BYTES-1:0]              o_lane_en,
    output cache_pkg::line_u                              o_wdata,
    output logic                                          o_dirty,
    output logic                                          o_touch,
    output cache_pkg::way_idx_t                           o_touch_way,
    output cache_pkg::line_addr_t                         o_m_addr,
    output cache_pkg::line_u                              o_m_writedata,
    output logic                                          o_m_read,
    output logic                                          o_m_write
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_COMP,
        S_WR_HIT,
        S_FETCH_REQ,
        S_FETCH_WAIT,
        S_MERGE,
        S_WB_SETUP,
        S_WB_WAIT
    } state_t;

    state_t   state;
    p_req_t   req_q;
    way_idx_t tgt_q;     // way chosen in compare, kept to the end

    logic [1:0]          word_sel;
    line_addr_t          req_line;
    logic                req_write;
    logic [NUM_WAYS-1:0] hit;
    way_idx_t            hit_way;
    way_idx_t            free_way;
    way_idx_t            tgt_way;
    logic                any_free;
    logic                fill;

    assign word_sel  = req_q.addr[1:0];
    assign req_line  = req_q.addr[P_ADDR_W-1:2];
    assign req_write = req_q.wr && !req_q.rd;

    // arrays are read straight from the bus while idle so compare sees them next cycle
    assign o_index = (state == S_IDLE) ? i_p_req.addr[INDEX_W+1:2] : req_line[INDEX_W-1:0];
    assign o_tag   = req_line[LINE_ADDR_W-1:INDEX_W];

    assign o_p_waitrequest = (state != S_IDLE);

    // lowest numbered way wins both searches
    always_comb begin
        hit_way  = '0;
        free_way = '0;
        any_free = 1'b0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            hit[w] = i_valid[w] && (i_tag[w] == o_tag);
            if (hit[w]) begin
                hit_way = way_idx_t'(w);
            end
            if (!i_valid[w]) begin
                free_way = way_idx_t'(w);
                any_free = 1'b1;
            end
        end
    end

    assign tgt_way = (|hit) ? hit_way : (any_free ? free_way : i_victim);

    assign o_touch     = (state == S_COMP);
    assign o_touch_way = tgt_way;

    // refill line arrives; zero latency after the command is also taken
    assign fill = i_m_readdata_valid &&
                  ((state == S_FETCH_WAIT) || (state == S_FETCH_REQ && !i_m_waitrequest));

    always_comb begin
        if (fill || state == S_WR_HIT || state == S_MERGE) begin
            o_wr_mask = way_mask_t'(1) << tgt_q;
        end else begin
            o_wr_mask = '0;
        end
        if (fill) begin
            o_lane_en = '1;
            o_wdata   = i_m_readdata;
        end else begin
            o_lane_en     = LINE_BYTES'(req_q.be) << {word_sel, 2'b00};
            o_wdata.words = {WORDS_PER_LINE{req_q.data}};
        end
    end

    assign o_dirty = !fill;   // processor writes mark the line

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= S_IDLE;
            o_p_readdata_valid <= 1'b0;
            o_m_read           <= 1'b0;
            o_m_write          <= 1'b0;
        end else begin
            o_p_readdata_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    req_q <= i_p_req;
                    if (i_p_req.rd || i_p_req.wr) begin
                        state <= S_COMP;
                    end
                end
                S_COMP: begin
                    tgt_q <= tgt_way;
                    if (|hit) begin
                        if (req_write) begin
                            state <= S_WR_HIT;
                        end else begin
                            o_p_readdata       <= i_line[hit_way].words[word_sel];
                            o_p_readdata_valid <= 1'b1;
                            state              <= S_IDLE;
                        end
                    end else if (i_valid[tgt_way] && i_dirty[tgt_way]) begin
                        state <= S_WB_SETUP;
                    end else begin
                        o_m_addr <= req_line;
                        o_m_read <= 1'b1;
                        state    <= S_FETCH_REQ;
                    end
                end
                S_WR_HIT, S_MERGE: begin
                    state <= S_IDLE;
                end
                S_WB_SETUP: begin
                    // victim still on the way outputs, nothing was written since compare
                    o_m_addr      <= {i_tag[tgt_q], req_line[INDEX_W-1:0]};
                    o_m_writedata <= i_line[tgt_q];
                    o_m_write     <= 1'b1;
                    state         <= S_WB_WAIT;
                end
                S_WB_WAIT: begin
                    if (!i_m_waitrequest) begin
                        o_m_write <= 1'b0;
                        o_m_addr  <= req_line;
                        o_m_read  <= 1'b1;
                        state     <= S_FETCH_REQ;
                    end
                end
                S_FETCH_REQ, S_FETCH_WAIT: begin
                    if (state == S_FETCH_REQ && !i_m_waitrequest) begin
                        o_m_read <= 1'b0;
                        state    <= S_FETCH_WAIT;
                    end
                    if (fill) begin
                        if (req_write) begin
                            state <= S_MERGE;   // word goes in on top of the new line
                        end else begin
                            o_p_readdata       <= i_m_readdata.words[word_sel];
                            o_p_readdata_valid <= 1'b1;
                            state              <= S_IDLE;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/lru_store.sv
`timescale 1ns/100ps
// per-set recency order, top pair most recent, bottom pair least recent
// o_victim follows i_index by one cycle and shows the order before a touch
module lru_store #(
    parameter int INDEX_W = cache_pkg::INDEX_W_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [INDEX_W-1:0]   i_index,
    input  logic                 i_touch,
    input  cache_pkg::way_idx_t  i_way,
    output cache_pkg::way_idx_t  o_victim
);
    import cache_pkg::*;

    localparam int SETS = 2 ** INDEX_W;

    typedef way_idx_t [NUM_WAYS-1:0] order_t;

    localparam order_t RESET_ORDER = order_t'(8'b11_10_01_00);  // way 0 is oldest

    order_t order_q [SETS];

    // move w to the top, ways that were above it drop by one
    function automatic order_t promote(order_t ord, way_idx_t w);
        order_t nxt;
        logic   seen;
        nxt  = ord;
        seen = 1'b0;
        for (int k = 0; k < NUM_WAYS - 1; k++) begin
            if (ord[k] == w) begin
                seen = 1'b1;
            end
            if (seen) begin
                nxt[k] = ord[k+1];
            end
        end
        nxt[NUM_WAYS-1] = w;
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                order_q[s] <= RESET_ORDER;
            end
            o_victim <= '0;
        end else begin
            if (i_touch) begin
                order_q[i_index] <= promote(order_q[i_index], i_way);
            end
            o_victim <= order_q[i_index][0];
        end
    end

endmodule

//--- rtl/cache_way.sv
`timescale 1ns/100ps
// one way of the cache; all outputs are one cycle behind i_index
// a read and a write to the same set in one cycle return the old contents
module cache_way #(
    parameter int INDEX_W = cache_pkg::INDEX_W_DEFAULT,
    localparam int TAG_W = cache_pkg::LINE_ADDR_W - INDEX_W
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [INDEX_W-1:0]               i_index,
    input  logic [TAG_W-1:0]                 i_tag,
    input  logic                             i_wr,
    input  logic [cache_pkg::LINE_BYTES-1:0] i_lane_en,
    input  cache_pkg::line_u                 i_wdata,
    input  logic                             i_dirty,
    output cache_pkg::line_u                 o_line,
    output logic [TAG_W-1:0]                 o_tag,
    output logic                             o_valid,
    output logic                             o_dirty
);
    import cache_pkg::*;

    localparam int SETS = 2 ** INDEX_W;

    logic [LINE_BYTES-1:0][7:0] data_mem [SETS];
    logic [TAG_W-1:0]           tag_mem  [SETS];
    logic                       dirty_mem[SETS];
    logic [SETS-1:0]            valid_q;

    // byte-lane data array
    always_ff @(posedge clk) begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (i_wr && i_lane_en[b]) begin
                data_mem[i_index][b] <= i_wdata.bytes[b];
            end
        end
        o_line <= data_mem[i_index];
    end

    // tag and dirty go in together on every write
    always_ff @(posedge clk) begin
        if (i_wr) begin
            tag_mem[i_index]   <= i_tag;
            dirty_mem[i_index] <= i_dirty;
        end
        o_tag   <= tag_mem[i_index];
        o_dirty <= dirty_mem[i_index];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            o_valid <= 1'b0;
        end else begin
            if (i_wr) begin
                valid_q[i_index] <= 1'b1;
            end
            o_valid <= valid_q[i_index];
        end
    end

endmodule

//--- rtl/cache_pkg.sv
// widths and types shared by the cache blocks
// line size and way count are fixed; the set count is a top-level parameter
package cache_pkg;

    localparam int NUM_WAYS        = 4;
    localparam int WORDS_PER_LINE  = 4;
    localparam int LINE_BYTES      = WORDS_PER_LINE * 4;
    localparam int P_ADDR_W        = 25;   // word address
    localparam int LINE_ADDR_W     = 23;   // word address without word select
    localparam int INDEX_W_DEFAULT = 4;

    typedef logic [31:0] word_t;
    typedef logic [P_ADDR_W-1:0] p_addr_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    // word 0 sits in the low bits, byte 0 likewise
    typedef union packed {
        word_t [WORDS_PER_LINE-1:0]   words;
        logic  [LINE_BYTES-1:0][7:0]  bytes;
    } line_u;

    typedef struct packed {
        logic    rd;
        logic    wr;     // ignored when rd is also set
        p_addr_t addr;
        logic [3:0] be;
        word_t   data;
    } p_req_t;

    typedef logic [NUM_WAYS-1:0] way_mask_t;  // one-hot
    typedef logic [1:0] way_idx_t;

endpackage
